/* hdl/pdp8Pkg.sv */
// Types shared by the 12-bit CPU, which has no MQ, no interrupts and a single teleprinter device
`default_nettype none

package pdp8Pkg;

  // Data word and memory address are both 12 bits wide
  typedef logic [11:0] word;
  typedef logic [11:0] addr;

  // One teleprinter character
  typedef logic [7:0] ttyCharT;

  // Decoded view of the current instruction
  typedef struct packed {
    // One-hot major opcode
    logic isAnd;
    logic isTad;
    logic isIsz;
    logic isDca;
    logic isJms;
    logic isJmp;
    logic isIot;
    logic isOpr;
    // Addressing mode of memory reference instructions
    logic isIndirect;
    logic isAutoIndex;
    addr  effAddr;
    // Group 1 micro-ops, CLA is shared with group 2
    logic oprCla;
    logic oprCll;
    logic oprCma;
    logic oprCml;
    logic oprRar;
    logic oprRal;
    logic oprTwice;
    logic oprIac;
    // Group 2 skip tests and sense inversion
    logic skpSma;
    logic skpSza;
    logic skpSnl;
    logic skpInv;
    logic isHalt;
    // Device 04 functions
    logic isTsf;
    logic isTls;
  } instFlags;

  // Front panel operations, opNone must stay at zero
  typedef enum logic [2:0] {
    opNone,
    opLoadPc,
    opDeposit,
    opExamine,
    opRun,
    opHalt
  } panelOp;

  typedef struct packed {
    panelOp op;
    addr    address;
    word    data;
  } panelCmd;

  // Outgoing character beat
  typedef struct packed {
    logic    valid;
    ttyCharT data;
  } ttyBeat;

  // Major states of the sequencer
  typedef enum logic [3:0] {
    seqIdle,
    seqFetchAddr,
    seqFetchData,
    seqDeferAddr,
    seqDeferData,
    seqAutoWrite,
    seqExecAddr,
    seqExecData,
    seqExecWrite,
    seqIoWait
  } seqState;

endpackage

`default_nettype wire

/* hdl/coreMemory.sv */
// 4096 x 12 single-port RAM whose read data arrives one cycle after the address and whose contents have no reset
`default_nettype none

module coreMemory (
  input  logic         SYSCLK,
  input  pdp8Pkg::addr addr,
  input  pdp8Pkg::word wData,
  input  logic         we,
  output pdp8Pkg::word rData
);
  import pdp8Pkg::*;

  // Full 12-bit address space
  word mem [4096];

  // Registered read port
  // On a write the new word is returned
  always_ff @(posedge SYSCLK) begin
    if (we) begin
      mem[addr] <= wData;
      rData     <= wData;
    end else begin
      rData <= mem[addr];
    end
  end

endmodule

`default_nettype wire

/* hdl/instDecoder.sv */
// Purely combinational decode where group 3 operates and IOTs of devices other than 04 decode as no-ops
`default_nettype none

module instDecoder (
  input  pdp8Pkg::word      ir,
  input  pdp8Pkg::addr      pcLat,
  output pdp8Pkg::instFlags flags
);
  import pdp8Pkg::*;

  logic [2:0] opcode;
  logic       memRef;
  logic       group1;
  logic       group2;
  logic       ttyDev;
  addr        operand;

  assign opcode = ir[11:9];
  // Opcodes 0 to 5 reference memory
  assign memRef = opcode < 3'd6;
  // Bit 7 selects the current page, else page zero
  assign operand = {ir[7] ? pcLat[11:7] : 5'b00000, ir[6:0]};
  assign group1 = (opcode == 3'd7) && !ir[8];
  assign group2 = (opcode == 3'd7) && ir[8] && !ir[0];
  // Teleprinter output is device 04
  assign ttyDev = (opcode == 3'd6) && (ir[8:3] == 6'o04);

  always_comb begin
    flags = '0;
    flags.isAnd = opcode == 3'd0;
    flags.isTad = opcode == 3'd1;
    flags.isIsz = opcode == 3'd2;
    flags.isDca = opcode == 3'd3;
    flags.isJms = opcode == 3'd4;
    flags.isJmp = opcode == 3'd5;
    flags.isIot = opcode == 3'd6;
    flags.isOpr = opcode == 3'd7;
    flags.isIndirect = memRef && ir[8];
    // Indirect through 0010 to 0017 bumps the pointer first
    flags.isAutoIndex = memRef && ir[8] && (operand[11:3] == 9'o001);
    flags.effAddr = operand;
    flags.oprCla = (group1 || group2) && ir[7];
    if (group1) begin
      flags.oprCll   = ir[6];
      flags.oprCma   = ir[5];
      flags.oprCml   = ir[4];
      flags.oprRar   = ir[3];
      flags.oprRal   = ir[2];
      flags.oprTwice = ir[1];
      flags.oprIac   = ir[0];
    end
    // OSR in bit 2 is ignored
    if (group2) begin
      flags.skpSma = ir[6];
      flags.skpSza = ir[5];
      flags.skpSnl = ir[4];
      flags.skpInv = ir[3];
      flags.isHalt = ir[1];
    end
    flags.isTsf = ttyDev && (ir[2:0] == 3'o1);
    flags.isTls = ttyDev && (ir[2:0] == 3'o6);
  end

endmodule

`default_nettype wire

/* hdl/accUnit.sv */
// AC and link only, the strobes are expected one at a time and a RAR combined with RAL acts as RAR
`default_nettype none

module accUnit (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  pdp8Pkg::instFlags flags,
  input  pdp8Pkg::word      memData,
  input  logic              acLoadAdd,
  input  logic              acLoadAnd,
  input  logic              acClear,
  input  logic              oprStep,
  output pdp8Pkg::word      ac,
  output logic              link,
  output logic              skipTaken
);
  import pdp8Pkg::*;

  word         sum;
  logic        sumCarry;
  word         clrAc;
  word         cmpAc;
  word         incAc;
  word         oprAc;
  logic        clrLink;
  logic        cmpLink;
  logic        incLink;
  logic        oprLink;
  logic        incCarry;
  logic [12:0] rotIn;
  logic        testHit;

  // TAD adder, carry out flips the link
  assign {sumCarry, sum} = {1'b0, ac} + {1'b0, memData};

  // Group 1 chain in machine order
  always_comb begin
    clrAc   = flags.oprCla ? '0 : ac;
    clrLink = flags.oprCll ? 1'b0 : link;
    cmpAc   = flags.oprCma ? ~clrAc : clrAc;
    cmpLink = clrLink ^ flags.oprCml;
    {incCarry, incAc} = {1'b0, cmpAc} + {12'd0, flags.oprIac};
    incLink = cmpLink ^ incCarry;
    // Rotates work on the 13-bit link and AC pair
    rotIn = {incLink, incAc};
    {oprLink, oprAc} = rotIn;
    if (flags.oprRar) begin
      {oprLink, oprAc} = flags.oprTwice ? {rotIn[1:0], rotIn[12:2]} : {rotIn[0], rotIn[12:1]};
    end else if (flags.oprRal) begin
      {oprLink, oprAc} = flags.oprTwice ? {rotIn[10:0], rotIn[12:11]} : {rotIn[11:0], rotIn[12]};
    end else if (flags.oprTwice) begin
      // BSW leaves the link alone
      oprAc = {incAc[5:0], incAc[11:6]};
    end
  end

  // Group 2 tests see AC before any CLA
  assign testHit = (flags.skpSma && ac[11])
                || (flags.skpSza && ac == '0)
                || (flags.skpSnl && link);
  // Inverted sense skips only when every selected test fails
  assign skipTaken = testHit ^ flags.skpInv;

  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      ac   <= '0;
      link <= 1'b0;
    end else if (acLoadAdd) begin
      ac   <= sum;
      link <= link ^ sumCarry;
    end else if (acLoadAnd) begin
      ac <= ac & memData;
    end else if (acClear) begin
      // DCA leaves AC cleared
      ac <= '0;
    end else if (oprStep) begin
      ac   <= oprAc;
      link <= oprLink;
    end
  end

endmodule

`default_nettype wire

/* hdl/ttyOut.sv */
// The receiver must return exactly one credit per character and never more than TTY_CREDITS in total
`default_nettype none

module ttyOut #(
  parameter int TTY_CREDITS = 2
) (
  input  logic             SYSCLK,
  input  logic             rstN,
  input  logic             tlsStrobe,
  input  pdp8Pkg::ttyCharT tlsChar,
  output logic             ttyReady,
  output pdp8Pkg::ttyBeat  beat,
  input  logic             ttyCredit
);
  import pdp8Pkg::*;

  localparam int CW = $clog2(TTY_CREDITS + 1);

  logic [CW-1:0] credits;
  logic          send;
  logic          sendQ;
  ttyCharT       charQ;

  // TSF and TLS both need a credit in hand
  assign ttyReady = credits != '0;
  assign send = tlsStrobe && ttyReady;
  assign beat = '{valid: sendQ, data: charQ};

  // Credit count and one-cycle valid
  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      credits <= CW'(TTY_CREDITS);
      sendQ   <= 1'b0;
    end else begin
      sendQ <= send;
      // A send and a return in the same cycle cancel
      case ({send, ttyCredit})
        2'b10: credits <= credits - 1'b1;
        2'b01: credits <= credits + 1'b1;
        default: ;
      endcase
    end
  end

  // Character register
  always_ff @(posedge SYSCLK) begin
    if (send) begin
      charQ <= tlsChar;
    end
  end

endmodule

`default_nettype wire

/* hdl/controlSequencer.sv */
// Panel commands are served only while halted and a panel halt stops the CPU at the next instruction boundary
`default_nettype none

module controlSequencer (
  input  logic              SYSCLK,
  input  logic              rstN,
  input  pdp8Pkg::panelCmd  panel,
  output pdp8Pkg::word      examData,
  output logic              examValid,
  output pdp8Pkg::addr      memAddr,
  output pdp8Pkg::word      memWData,
  output logic              memWe,
  input  pdp8Pkg::word      memRData,
  output pdp8Pkg::word      ir,
  output pdp8Pkg::addr      pcLat,
  input  pdp8Pkg::instFlags flags,
  output logic              acLoadAdd,
  output logic              acLoadAnd,
  output logic              acClear,
  output logic              oprStep,
  input  logic              skipTaken,
  input  pdp8Pkg::word      ac,
  input  logic              ttyReady,
  output logic              tlsStrobe,
  output logic              halted,
  output logic              instRetire,
  output pdp8Pkg::addr      pc
);
  import pdp8Pkg::*;

  seqState state;
  panelCmd panelReg;
  word     irReg;
  addr     ma;
  word     mb;
  logic    haltReq;
  logic    memRef;
  logic    skipNow;
  logic    stopNow;
  logic    lastCycle;

  // Decode sees the fetched word directly while it is on the read port
  assign ir = (state == seqFetchData) ? memRData : irReg;
  // Examine data comes straight from the read port, examValid marks it
  assign examData = memRData;

  assign memRef = !(flags.isOpr || flags.isIot);
  // Skip source depends on the instruction class
  assign skipNow = flags.isOpr ? skipTaken : (flags.isTsf && ttyReady);
  assign stopNow = haltReq || (panelReg.op == opHalt) || flags.isHalt;

  // Memory port, accumulator strobes and end-of-instruction detect
  always_comb begin
    memAddr   = pc;
    memWData  = mb;
    memWe     = 1'b0;
    acLoadAdd = 1'b0;
    acLoadAnd = 1'b0;
    acClear   = 1'b0;
    oprStep   = 1'b0;
    tlsStrobe = 1'b0;
    lastCycle = 1'b0;
    case (state)
      seqIdle: begin
        memAddr  = panelReg.address;
        memWData = panelReg.data;
        memWe    = (panelReg.op == opDeposit);
      end
      seqDeferAddr: memAddr = flags.effAddr;
      // Pointer write-back for 0010 to 0017
      seqAutoWrite: begin
        memAddr  = flags.effAddr;
        memWData = ma;
        memWe    = 1'b1;
      end
      seqExecAddr: begin
        memAddr   = ma;
        oprStep   = flags.isOpr;
        tlsStrobe = flags.isTls && ttyReady;
        // Operate and IOT finish here unless TLS lacks a credit
        lastCycle = !memRef && !(flags.isTls && !ttyReady);
      end
      seqExecData: begin
        memAddr   = ma;
        acLoadAnd = flags.isAnd;
        acLoadAdd = flags.isTad;
        lastCycle = flags.isAnd || flags.isTad || flags.isJmp;
      end
      seqExecWrite: begin
        memAddr   = ma;
        memWe     = 1'b1;
        acClear   = flags.isDca;
        lastCycle = 1'b1;
      end
      seqIoWait: begin
        tlsStrobe = ttyReady;
        lastCycle = ttyReady;
      end
      default: ;
    endcase
  end

  // Control state, PC and panel handling
  always_ff @(posedge SYSCLK or negedge rstN) begin
    if (!rstN) begin
      state      <= seqIdle;
      pc         <= '0;
      panelReg   <= '0;
      haltReq    <= 1'b0;
      halted     <= 1'b1;
      instRetire <= 1'b0;
      examValid  <= 1'b0;
    end else begin
      panelReg   <= panel;
      instRetire <= lastCycle;
      examValid  <= (state == seqIdle) && (panelReg.op == opExamine);
      // Remember a panel halt until the instruction ends
      if (!halted && panelReg.op == opHalt) begin
        haltReq <= 1'b1;
      end
      case (state)
        seqIdle: begin
          if (panelReg.op == opLoadPc) begin
            pc <= panelReg.address;
          end
          if (panelReg.op == opRun) begin
            halted <= 1'b0;
            state  <= seqFetchAddr;
          end
        end
        seqFetchAddr: begin
          pc    <= pc + 12'd1;
          state <= seqFetchData;
        end
        seqFetchData: state <= flags.isIndirect ? seqDeferAddr : seqExecAddr;
        seqDeferAddr: state <= seqDeferData;
        seqDeferData: state <= flags.isAutoIndex ? seqAutoWrite : seqExecAddr;
        seqAutoWrite: state <= seqExecAddr;
        seqExecAddr: begin
          pc    <= pc + {11'd0, skipNow};
          // ioWait only holds when TLS finds no credit
          state <= memRef ? seqExecData : seqIoWait;
        end
        seqExecData: begin
          if (flags.isJmp) begin
            pc <= ma;
          end
          state <= seqExecWrite;
        end
        seqExecWrite: begin
          // JMS stores the return address and continues after it
          if (flags.isJms) begin
            pc <= ma + 12'd1;
          end else if (flags.isIsz && mb == '0) begin
            pc <= pc + 12'd1;
          end
        end
        seqIoWait: ;
        default: state <= seqIdle;
      endcase
      // Instruction boundary overrides the next state
      if (lastCycle) begin
        state <= stopNow ? seqIdle : seqFetchAddr;
        if (stopNow) begin
          halted  <= 1'b1;
          haltReq <= 1'b0;
        end
      end
    end
  end

  // IR, MA, MB and the latched PC
  always_ff @(posedge SYSCLK) begin
    case (state)
      seqFetchAddr: pcLat <= pc;
      seqFetchData: begin
        irReg <= memRData;
        ma    <= flags.effAddr;
      end
      seqDeferData: ma <= flags.isAutoIndex ? memRData + 12'd1 : memRData;
      seqExecData: begin
        if (flags.isIsz) begin
          mb <= memRData + 12'd1;
        end else if (flags.isJms) begin
          mb <= pc;
        end else begin
          mb <= ac;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/pdp8Top.sv */
// Panel commands last one cycle and the teleprinter receiver holds TTY_CREDITS characters
`default_nettype none

module pdp8Top #(
  parameter int TTY_CREDITS = 2
) (
  input  logic             SYSCLK,
  input  logic             rstN,
  input  pdp8Pkg::panelCmd panel,
  output pdp8Pkg::word     examData,
  output logic             examValid,
  output pdp8Pkg::ttyBeat  ttyBeat,
  input  logic             ttyCredit,
  output pdp8Pkg::addr     pc,
  output pdp8Pkg::word     ac,
  output logic             link,
  output logic             halted,
  output logic             instRetire
);
  import pdp8Pkg::*;

  // Memory port
  addr      memAddr;
  word      memWData;
  logic     memWe;
  word      memRData;
  // Decode
  word      ir;
  addr      pcLat;
  instFlags flags;
  // Accumulator strobes
  logic     acLoadAdd;
  logic     acLoadAnd;
  logic     acClear;
  logic     oprStep;
  logic     skipTaken;
  // Teleprinter handshake
  logic     ttyReady;
  logic     tlsStrobe;

  controlSequencer theSequencer (
    .SYSCLK(SYSCLK), .rstN(rstN), .panel(panel),
    .examData(examData), .examValid(examValid),
    .memAddr(memAddr), .memWData(memWData), .memWe(memWe), .memRData(memRData),
    .ir(ir), .pcLat(pcLat), .flags(flags),
    .acLoadAdd(acLoadAdd), .acLoadAnd(acLoadAnd), .acClear(acClear), .oprStep(oprStep),
    .skipTaken(skipTaken), .ac(ac), .ttyReady(ttyReady), .tlsStrobe(tlsStrobe),
    .halted(halted), .instRetire(instRetire), .pc(pc)
  );

  coreMemory theMemory (
    .SYSCLK(SYSCLK), .addr(memAddr), .wData(memWData), .we(memWe), .rData(memRData)
  );

  instDecoder theDecoder (
    .ir(ir), .pcLat(pcLat), .flags(flags)
  );

  accUnit theAcc (
    .SYSCLK(SYSCLK), .rstN(rstN), .flags(flags), .memData(memRData),
    .acLoadAdd(acLoadAdd), .acLoadAnd(acLoadAnd), .acClear(acClear), .oprStep(oprStep),
    .ac(ac), .link(link), .skipTaken(skipTaken)
  );

  // TLS sends the low byte of AC
  ttyOut #(.TTY_CREDITS(TTY_CREDITS)) theTty (
    .SYSCLK(SYSCLK), .rstN(rstN), .tlsStrobe(tlsStrobe), .tlsChar(ac[7:0]),
    .ttyReady(ttyReady), .beat(ttyBeat), .ttyCredit(ttyCredit)
  );

endmodule

`default_nettype wire

/* test/pdp8TbModel.svh */
// Instruction-level CPU model where TSF always counts as ready, group 3 is not modeled and programs stop at HLT
`ifndef PDP8_TB_MODEL_SVH
`define PDP8_TB_MODEL_SVH

// Model machine state, kept across programs like the DUT
word         mMem [4096];
word         mAc = '0;
logic        mLink = 1'b0;
addr         mPc;
// Link, AC and PC expected after each instruction
logic [24:0] expRetire [$];
ttyCharT     expChars [$];
// Locations a program image defines, deposited and later examined
addr         placed [$];
int unsigned rngState = 26383;

function automatic int unsigned xorshift(int unsigned s);
  s ^= s << 13;
  s ^= s >> 17;
  s ^= s << 5;
  return s;
endfunction

function automatic word nextRand();
  rngState = xorshift(rngState);
  return rngState[11:0];
endfunction

task automatic place(addr a, word w);
  mMem[a] = w;
  placed.push_back(a);
endtask

task automatic modelRun(input addr start, output int steps);
  word         ir;
  addr         pcl;
  addr         ea;
  logic [12:0] r;
  logic        hit;
  logic        stop;
  mPc = start;
  steps = 0;
  stop = 1'b0;
  while (!stop && steps < 4000) begin
    ir = mMem[mPc];
    pcl = mPc;
    mPc = mPc + 12'd1;
    // Page zero or current page, then one level of indirection
    ea = {ir[7] ? pcl[11:7] : 5'd0, ir[6:0]};
    if (ir[11:9] < 3'd6 && ir[8]) begin
      if (ea[11:3] == 9'o001) begin
        mMem[ea] = mMem[ea] + 12'd1;
      end
      ea = mMem[ea];
    end
    case (ir[11:9])
      3'd0: mAc = mAc & mMem[ea];
      3'd1: begin
        r = {1'b0, mAc} + {1'b0, mMem[ea]};
        mAc = r[11:0];
        mLink = mLink ^ r[12];
      end
      3'd2: begin
        mMem[ea] = mMem[ea] + 12'd1;
        if (mMem[ea] == '0) begin
          mPc = mPc + 12'd1;
        end
      end
      3'd3: begin
        mMem[ea] = mAc;
        mAc = '0;
      end
      3'd4: begin
        mMem[ea] = mPc;
        mPc = ea + 12'd1;
      end
      3'd5: mPc = ea;
      3'd6: begin
        if (ir == 12'o6041) begin
          mPc = mPc + 12'd1;
        end
        if (ir == 12'o6046) begin
          expChars.push_back(mAc[7:0]);
        end
      end
      default: begin
        if (!ir[8]) begin
          // Group 1 in machine order
          if (ir[7]) mAc = '0;
          if (ir[6]) mLink = 1'b0;
          if (ir[5]) mAc = ~mAc;
          if (ir[4]) mLink = ~mLink;
          r = {mLink, mAc} + {12'd0, ir[0]};
          if (ir[3]) begin
            repeat (ir[1] ? 2 : 1) r = {r[0], r[12:1]};
          end else if (ir[2]) begin
            repeat (ir[1] ? 2 : 1) r = {r[11:0], r[12]};
          end else if (ir[1]) begin
            r[11:0] = {r[5:0], r[11:6]};
          end
          {mLink, mAc} = r;
        end else if (!ir[0]) begin
          // Group 2 tests use AC before CLA
          hit = (ir[6] && mAc[11]) || (ir[5] && mAc == '0) || (ir[4] && mLink);
          if (hit != ir[3]) mPc = mPc + 12'd1;
          if (ir[7]) mAc = '0;
          stop = ir[1];
        end
      end
    endcase
    expRetire.push_back({mLink, mAc, mPc});
    steps++;
  end
endtask

`endif

/* test/pdp8Tb.sv */
// Programs read only locations they deposit, and the credit receiver holds TTY_CREDITS characters
`default_nettype none

module pdp8Tb;
  import pdp8Pkg::*;

  localparam int TTY_CREDITS = 2;

  logic        SYSCLK = 1'b0;
  logic        rstN;
  panelCmd     panel;
  word         examData;
  logic        examValid;
  ttyBeat      beat;
  logic        ttyCredit = 1'b0;
  addr         pc;
  word         ac;
  logic        link;
  logic        halted;
  logic        instRetire;
  int          errors = 0;
  int          checks = 0;
  int          budgetCycles = 200;
  int          cycles = 0;
  int          retireCount = 0;
  bit          retireChk = 1'b0;
  logic [24:0] retExp;
  // Characters sent but not yet credited back
  int          outstanding = 0;
  int          creditWait = 0;
  int unsigned creditRng = 26383;
  ttyCharT     gotChars [$];

  `include "pdp8TbModel.svh"

  pdp8Top #(.TTY_CREDITS(TTY_CREDITS)) pdp8Top_i (
    .SYSCLK(SYSCLK), .rstN(rstN), .panel(panel), .examData(examData), .examValid(examValid),
    .ttyBeat(beat), .ttyCredit(ttyCredit), .pc(pc), .ac(ac), .link(link),
    .halted(halted), .instRetire(instRetire)
  );

  always #10 SYSCLK = ~SYSCLK;

  task automatic checkVal(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("MISMATCH %s expected %0o actual %0o", name, exp, act);
    end
  endtask

  task automatic reportFault(string msg);
    errors++;
    $display("ERROR %s", msg);
  endtask

  // One-cycle panel command, entered and left on a falling edge
  task automatic sendPanel(panelOp op, addr a, word d);
    panel = '{op: op, address: a, data: d};
    @(negedge SYSCLK);
    panel = '0;
    budgetCycles += 4;
  endtask

  task automatic examine(addr a, output word d);
    int n;
    sendPanel(opExamine, a, '0);
    n = 0;
    while (!examValid && n < 8) begin
      @(negedge SYSCLK);
      n++;
    end
    assert (examValid) else reportFault($sformatf("examine of %04o returned no data", a));
    d = examData;
  endtask

  task automatic depositPlaced();
    foreach (placed[i]) sendPanel(opDeposit, placed[i], mMem[placed[i]]);
  endtask

  task automatic examinePlaced(string name);
    word d;
    foreach (placed[i]) begin
      examine(placed[i], d);
      checkVal($sformatf("%s mem %04o", name, placed[i]), mMem[placed[i]], d);
    end
    placed.delete();
  endtask

  task automatic startCpu(addr start);
    sendPanel(opLoadPc, start, '0);
    sendPanel(opRun, '0, '0);
    while (halted) @(negedge SYSCLK);
  endtask

  task automatic runProgram(string name, addr start, bit chkRet);
    int steps;
    depositPlaced();
    expRetire.delete();
    modelRun(start, steps);
    budgetCycles += steps * 12 + 40 * expChars.size() + 20;
    retireChk = chkRet;
    startCpu(start);
    while (!halted) @(negedge SYSCLK);
    // Let the monitor take the HLT retire first
    @(negedge SYSCLK);
    retireChk = 1'b0;
    checkVal({name, " pc"}, mPc, pc);
    checkVal({name, " ac"}, mAc, ac);
    checkVal({name, " link"}, mLink, link);
    if (chkRet) checkVal({name, " retires left"}, 0, expRetire.size());
    examinePlaced(name);
  endtask

  task automatic buildArith();
    word prog [11] = '{12'o7300, 12'o1300, 12'o1301, 12'o3302, 12'o1300, 12'o0301,
                       12'o3303, 12'o1301, 12'o1050, 12'o1301, 12'o7402};
    foreach (prog[i]) place(12'o200 + 12'(i), prog[i]);
    place(12'o300, nextRand());
    place(12'o301, nextRand());
    place(12'o050, nextRand());
    place(12'o302, '0);
    place(12'o303, '0);
  endtask

  // Autoindex sum loop, JMS return, DCA through 0017, TAD I and JMP I
  task automatic buildIndirect();
    word prog [8] = '{12'o7300, 12'o1410, 12'o2020, 12'o5201, 12'o4221, 12'o3417,
                      12'o1423, 12'o5430};
    foreach (prog[i]) place(12'o400 + 12'(i), prog[i]);
    place(12'o421, '0);
    place(12'o422, 12'o1260);
    place(12'o423, 12'o5621);
    place(12'o440, 12'o7402);
    place(12'o010, 12'o477);
    place(12'o017, 12'o577);
    place(12'o020, 12'o7774);
    place(12'o023, 12'o560);
    place(12'o030, 12'o440);
    place(12'o460, nextRand());
    place(12'o560, nextRand());
    for (int i = 0; i < 4; i++) place(12'o500 + 12'(i), nextRand());
    place(12'o600, '0);
  endtask

  // Each op gets a random AC and link, then an IAC that a skip can jump
  task automatic buildOperate();
    word ops [17] = '{12'o7010, 12'o7004, 12'o7012, 12'o7006, 12'o7002, 12'o7040,
                      12'o7020, 12'o7001, 12'o7041, 12'o7500, 12'o7440, 12'o7420,
                      12'o7510, 12'o7450, 12'o7430, 12'o7410, 12'o7600};
    word r;
    foreach (ops[i]) begin
      r = nextRand();
      place(12'o1000 + 12'(4 * i), r[5] ? 12'o7320 : 12'o7300);
      place(12'o1001 + 12'(4 * i), 12'o1340 + 12'(i));
      place(12'o1002 + 12'(4 * i), ops[i]);
      place(12'o1003 + 12'(4 * i), 12'o7001);
      place(12'o1140 + 12'(i), (r[1:0] == 2'd0) ? '0 : nextRand());
    end
    place(12'o1104, 12'o7402);
  endtask

  // Ten characters through a TSF loop, then three bare TLS
  task automatic buildTty();
    word prog [11] = '{12'o7300, 12'o1411, 12'o6041, 12'o5202, 12'o6046, 12'o2025,
                       12'o5200, 12'o6046, 12'o6046, 12'o6046, 12'o7402};
    foreach (prog[i]) place(12'o1200 + 12'(i), prog[i]);
    place(12'o011, 12'o1277);
    place(12'o025, 12'o7766);
    for (int i = 0; i < 10; i++) place(12'o1300 + 12'(i), nextRand());
  endtask

  // Retire monitor
  always @(negedge SYSCLK) begin
    if (rstN && instRetire) begin
      retireCount++;
      if (retireChk) begin
        if (expRetire.size() == 0) begin
          reportFault("instruction retired after the model halted");
        end else begin
          retExp = expRetire.pop_front();
          checkVal("retire link/ac/pc", retExp, {link, ac, pc});
        end
      end
    end
  end

  // Receiver side with random credit return delays
  always @(negedge SYSCLK) begin
    if (rstN) begin
      if (beat.valid) begin
        gotChars.push_back(beat.data);
        outstanding++;
      end
      assert (outstanding <= TTY_CREDITS) else reportFault("too many characters outstanding");
      ttyCredit = 1'b0;
      if (outstanding > 0) begin
        if (creditWait == 0) begin
          ttyCredit = 1'b1;
          outstanding--;
          creditRng = xorshift(creditRng);
          creditWait = creditRng % 16;
        end else begin
          creditWait--;
        end
      end
    end
  end

  // Watchdog whose budget grows as each test is sized
  initial begin
    while (cycles <= budgetCycles) begin
      @(posedge SYSCLK);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles, CPU or panel stopped responding", cycles);
    $display("Regression failed");
    $finish;
  end

  initial begin
    word acStart;
    int  waitN;
    rstN = 1'b0;
    panel = '0;
    repeat (16) @(posedge SYSCLK);
    @(negedge SYSCLK);
    rstN = 1'b1;
    @(negedge SYSCLK);
    for (int i = 0; i < 64; i++) place(nextRand(), nextRand());
    depositPlaced();
    examinePlaced("deposit");
    repeat (4) begin
      buildArith();
      runProgram("arith", 12'o200, 1'b1);
    end
    buildIndirect();
    runProgram("indirect", 12'o400, 1'b1);
    buildOperate();
    runProgram("operate", 12'o1000, 1'b1);
    buildTty();
    runProgram("tty", 12'o1200, 1'b0);
    checkVal("tty count", expChars.size(), gotChars.size());
    foreach (expChars[i]) begin
      if (i < gotChars.size()) checkVal($sformatf("tty char %0d", i), expChars[i], gotChars[i]);
    end
    // HLT, then resume from the loaded PC after it
    place(12'o1400, 12'o7402);
    place(12'o1401, 12'o7001);
    place(12'o1402, 12'o7402);
    runProgram("halt", 12'o1400, 1'b1);
    runProgram("resume", 12'o1401, 1'b1);
    // IAC loop stopped from the panel
    place(12'o1500, 12'o7001);
    place(12'o1501, 12'o5300);
    depositPlaced();
    placed.delete();
    acStart = mAc;
    retireCount = 0;
    waitN = 20 + nextRand() % 64;
    budgetCycles += waitN + 60;
    startCpu(12'o1500);
    repeat (waitN) @(negedge SYSCLK);
    sendPanel(opHalt, '0, '0);
    while (!halted) @(negedge SYSCLK);
    @(negedge SYSCLK);
    checkVal("panel halt pc", (retireCount % 2) ? 12'o1501 : 12'o1500, pc);
    checkVal("panel halt ac", word'(acStart + word'((retireCount + 1) / 2)), ac);
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+test
hdl/pdp8Pkg.sv
hdl/coreMemory.sv
hdl/instDecoder.sv
hdl/accUnit.sv
hdl/ttyOut.sv
hdl/controlSequencer.sv
hdl/pdp8Top.sv
test/pdp8Tb.sv
